// File: source/trap_macros.svh
/*
 * trap unit widths and constants
 * shared by the packages and the RTL of the trap controller
 */
`ifndef TRAP_MACROS_SVH
`define TRAP_MACROS_SVH

// data and address width
`define TRAP_XLEN 32

// number of fast interrupt lines
`define TRAP_NUM_FAST_IRQ 15

// cause width with the msb marking an interrupt
`define TRAP_CAUSE_W 6

// cause code offset of fast interrupt 0
`define TRAP_FAST_IRQ_BASE 16

`endif

// File: source/trap_arch_pkg.sv
/*
 * architectural types of the trap controller
 * privilege levels, trap cause codes and pending interrupt lines
 */
`default_nettype none
`include "trap_macros.svh"

package trap_arch_pkg;

  // privilege levels of which only U and M exist
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  ////////////////////
  // cause codes
  ////////////////////

  // msb set for interrupts
  // fast interrupt i maps to 32+16+i by cast where needed
  typedef enum logic [`TRAP_CAUSE_W-1:0] {
    // synchronous exceptions
    INSTR_ACCESS_FAULT = 6'd1,
    ILLEGAL_INSN       = 6'd2,
    BREAKPOINT         = 6'd3,
    ECALL_U            = 6'd8,
    ECALL_M            = 6'd11,
    // machine interrupts
    IRQ_SOFTWARE       = 6'd35,
    IRQ_TIMER          = 6'd39,
    IRQ_EXTERNAL       = 6'd43,
    IRQ_NM             = 6'd63
  } exc_cause_e;

  ////////////////////
  // interrupt lines
  ////////////////////

  // pending lines as seen at acceptance
  typedef struct packed {
    logic [`TRAP_NUM_FAST_IRQ-1:0] irq_fast;
    logic                          irq_external;
    logic                          irq_software;
    logic                          irq_timer;
  } irqs_t;

endpackage

`default_nettype wire

// File: source/trap_ctrl_pkg.sv
/*
 * control types of the trap controller
 * FSM states, redirect targets and per-instruction outcomes
 */
`default_nettype none

package trap_ctrl_pkg;

  // top level controller states
  typedef enum logic [1:0] {
    RESET,
    BOOT_SET,
    RUN
  } ctrl_fsm_e;

  // redirect target select for the fetch stage
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // what happens to an accepted instruction
  typedef enum logic [1:0] {
    KIND_RETIRE,
    KIND_EXC,
    KIND_IRQ,
    KIND_MRET
  } trap_kind_e;

endpackage

`default_nettype wire

// File: source/trap_if.sv
/*
 * inter-stage links of the trap pipeline
 * request from capture to select, command from select to redirect
 */
`timescale 1ns/100ps
`default_nettype none
`include "trap_macros.svh"

// qualified request, registered at acceptance
interface trap_req_if
  import trap_arch_pkg::*;
();
  logic                  valid;
  logic                  is_irq;
  exc_cause_e            irq_cause;
  logic                  fetch_err;
  logic                  fetch_err_plus2;
  logic                  illegal;
  logic                  ecall;
  logic                  ebreak;
  logic                  mret;
  priv_lvl_e             priv;
  logic [`TRAP_XLEN-1:0] pc;
  logic [`TRAP_XLEN-1:0] instr;

  modport producer (output valid, is_irq, irq_cause, fetch_err, fetch_err_plus2,
                    illegal, ecall, ebreak, mret, priv, pc, instr);
  modport consumer (input  valid, is_irq, irq_cause, fetch_err, fetch_err_plus2,
                    illegal, ecall, ebreak, mret, priv, pc, instr);
endinterface

// resolved outcome, one per request
interface trap_cmd_if
  import trap_arch_pkg::*;
  import trap_ctrl_pkg::*;
();
  logic                  valid;
  trap_kind_e            kind;
  exc_cause_e            cause;
  logic [`TRAP_XLEN-1:0] mtval;
  logic [`TRAP_XLEN-1:0] epc;

  modport producer (output valid, kind, cause, mtval, epc);
  modport consumer (input  valid, kind, cause, mtval, epc);
endinterface

`default_nettype wire

// File: source/irq_arbiter.sv
/*
 * interrupt arbiter
 * decides if an interrupt is taken and encodes the winning cause
 */
`timescale 1ns/100ps
`default_nettype none
`include "trap_macros.svh"

module irq_arbiter
  import trap_arch_pkg::*;
(
  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  input  logic       mie_i,
  input  logic       nmi_mode_i,
  output logic       take_irq_o,
  output exc_cause_e irq_cause_o
);

  localparam int unsigned fast_idx_w = $clog2(`TRAP_NUM_FAST_IRQ);

  logic [fast_idx_w-1:0]     fast_idx;
  logic [`TRAP_CAUSE_W-1:0]  fast_code;

  // no nesting inside the NMI handler and NMI ignores mie
  assign take_irq_o = ~nmi_mode_i & (irq_nm_i | (mie_i & (|irqs_i)));

  // highest numbered pending fast line wins as later hits overwrite earlier ones
  always_comb begin
    fast_idx = '0;
    for (int i = 0; i < `TRAP_NUM_FAST_IRQ; i++) begin
      if (irqs_i.irq_fast[i]) begin
        fast_idx = fast_idx_w'(i);
      end
    end
  end

  // interrupt bit plus base offset plus line number
  assign fast_code = `TRAP_CAUSE_W'(1 << (`TRAP_CAUSE_W - 1))
                   + `TRAP_CAUSE_W'(`TRAP_FAST_IRQ_BASE)
                   + `TRAP_CAUSE_W'(fast_idx);

  // NMI, fast, external, software, timer
  always_comb begin
    if (irq_nm_i) begin
      irq_cause_o = IRQ_NM;
    end else if (|irqs_i.irq_fast) begin
      irq_cause_o = exc_cause_e'(fast_code);
    end else if (irqs_i.irq_external) begin
      irq_cause_o = IRQ_EXTERNAL;
    end else if (irqs_i.irq_software) begin
      irq_cause_o = IRQ_SOFTWARE;
    end else begin
      irq_cause_o = IRQ_TIMER;
    end
  end

endmodule

`default_nettype wire

// File: source/trap_capture.sv
/*
 * stage 1 of the trap pipeline
 * runs the instruction handshake, qualifies and registers the request
 */
`timescale 1ns/100ps
`default_nettype none
`include "trap_macros.svh"

module trap_capture
  import trap_arch_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid_i,
  input  logic [`TRAP_XLEN-1:0] instr_i,
  input  logic [`TRAP_XLEN-1:0] pc_i,
  input  priv_lvl_e             priv_i,
  input  logic                  illegal_i,
  input  logic                  ecall_i,
  input  logic                  ebreak_i,
  input  logic                  mret_i,
  input  logic                  fetch_err_i,
  input  logic                  fetch_err_plus2_i,
  input  irqs_t                 irqs_i,
  input  logic                  irq_nm_i,
  input  logic                  mie_i,
  input  logic                  nmi_mode_i,
  input  logic                  redirect_i,
  input  logic                  run_i,
  output logic                  id_ready_o,
  trap_req_if.producer          req
);

  logic       accept;
  logic       pending_q;
  logic       umode_mret;
  logic       illegal;
  logic       take_irq;
  logic       trap_in;
  exc_cause_e irq_cause;

  // interrupts are only looked at on acceptance
  irq_arbiter u_irq_arbiter (
    .irqs_i      (irqs_i),
    .irq_nm_i    (irq_nm_i),
    .mie_i       (mie_i),
    .nmi_mode_i  (nmi_mode_i),
    .take_irq_o  (take_irq),
    .irq_cause_o (irq_cause)
  );

  ////////////////////
  // handshake
  ////////////////////

  // closed until RUN and while a redirect is outstanding
  assign id_ready_o = run_i & ~pending_q;
  assign accept     = instr_valid_i & id_ready_o;

  // MRET is M-mode only
  assign umode_mret = mret_i & (priv_i != PRIV_M);
  assign illegal    = illegal_i | umode_mret;
  // anything that ends in a redirect
  assign trap_in    = take_irq | fetch_err_i | illegal | ecall_i | ebreak_i | mret_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req.valid <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      req.valid <= accept;
      // held until stage 3 fires the redirect
      if (redirect_i) begin
        pending_q <= 1'b0;
      end else if (accept && trap_in) begin
        pending_q <= 1'b1;
      end
    end
  end

  // request payload, loaded on acceptance only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req.is_irq          <= take_irq;
      req.irq_cause       <= irq_cause;
      req.fetch_err       <= fetch_err_i;
      req.fetch_err_plus2 <= fetch_err_plus2_i;
      req.illegal         <= illegal;
      req.ecall           <= ecall_i;
      req.ebreak          <= ebreak_i;
      req.mret            <= mret_i & ~umode_mret;
      req.priv            <= priv_i;
      req.pc              <= pc_i;
      req.instr           <= instr_i;
    end
  end

  // trap blocks acceptance until its redirect two edges later
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && trap_in) |=> !accept ##1 (!accept && redirect_i));

endmodule

`default_nettype wire

// File: source/trap_select.sv
/*
 * stage 2 of the trap pipeline
 * prioritizes the request, forms cause and mtval, registers the command
 */
`timescale 1ns/100ps
`default_nettype none
`include "trap_macros.svh"

module trap_select
  import trap_arch_pkg::*;
  import trap_ctrl_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  trap_req_if.consumer req,
  trap_cmd_if.producer cmd
);

  trap_kind_e            kind_d;
  exc_cause_e            cause_d;
  logic [`TRAP_XLEN-1:0] mtval_d;

  ////////////////////
  // priority
  ////////////////////

  // interrupt, fetch fault, illegal, ecall, ebreak, mret, retire
  always_comb begin
    kind_d  = KIND_RETIRE;
    // cause only matters for exceptions and interrupts
    cause_d = INSTR_ACCESS_FAULT;
    mtval_d = '0;
    if (req.is_irq) begin
      kind_d  = KIND_IRQ;
      cause_d = req.irq_cause;
    end else if (req.fetch_err) begin
      kind_d  = KIND_EXC;
      cause_d = INSTR_ACCESS_FAULT;
      // fault in the upper half of an unaligned fetch
      mtval_d = req.fetch_err_plus2 ? req.pc + `TRAP_XLEN'(2) : req.pc;
    end else if (req.illegal) begin
      kind_d  = KIND_EXC;
      cause_d = ILLEGAL_INSN;
      mtval_d = req.instr;
    end else if (req.ecall) begin
      kind_d  = KIND_EXC;
      cause_d = (req.priv == PRIV_M) ? ECALL_M : ECALL_U;
    end else if (req.ebreak) begin
      kind_d  = KIND_EXC;
      cause_d = BREAKPOINT;
    end else if (req.mret) begin
      kind_d  = KIND_MRET;
    end
  end

  ////////////////////
  // command register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= req.valid;
    end
  end

  // payload follows each valid request
  always_ff @(posedge clk_i) begin
    if (req.valid) begin
      cmd.kind  <= kind_d;
      cmd.cause <= cause_d;
      cmd.mtval <= mtval_d;
      cmd.epc   <= req.pc;
    end
  end

  // an exception never carries an interrupt code
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cmd.valid && cmd.kind == KIND_EXC) |-> !cmd.cause[`TRAP_CAUSE_W-1]);

endmodule

`default_nettype wire

// File: source/trap_fsm.sv
/*
 * stage 3 of the trap pipeline
 * reset/boot/run FSM, issues redirects, CSR save/restore and NMI mode
 */
`timescale 1ns/100ps
`default_nettype none
`include "trap_macros.svh"

module trap_fsm
  import trap_arch_pkg::*;
  import trap_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  trap_cmd_if.consumer          cmd,
  output logic                  pc_set_o,
  output pc_sel_e               pc_sel_o,
  output exc_cause_e            exc_cause_o,
  output logic [`TRAP_XLEN-1:0] mtval_o,
  output logic [`TRAP_XLEN-1:0] epc_o,
  output logic                  csr_save_o,
  output logic                  csr_restore_mret_o,
  output logic                  retire_o,
  output logic                  nmi_mode_o,
  output logic                  redirect_o,
  output logic                  run_o
);

  ctrl_fsm_e state_q;
  ctrl_fsm_e state_d;
  logic      nmi_mode_q;
  logic      nmi_mode_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d            = state_q;
    nmi_mode_d         = nmi_mode_q;
    pc_set_o           = 1'b0;
    pc_sel_o           = PC_BOOT;
    csr_save_o         = 1'b0;
    csr_restore_mret_o = 1'b0;
    retire_o           = 1'b0;
    redirect_o         = 1'b0;

    unique case (state_q)
      RESET: begin
        state_d = BOOT_SET;
      end
      BOOT_SET: begin
        // single boot redirect
        pc_set_o = 1'b1;
        pc_sel_o = PC_BOOT;
        state_d  = RUN;
      end
      RUN: begin
        if (cmd.valid) begin
          unique case (cmd.kind)
            KIND_RETIRE: begin
              retire_o = 1'b1;
            end
            KIND_EXC, KIND_IRQ: begin
              pc_set_o   = 1'b1;
              pc_sel_o   = PC_EXC;
              csr_save_o = 1'b1;
              redirect_o = 1'b1;
              // entering the NMI handler
              if (cmd.cause == IRQ_NM) begin
                nmi_mode_d = 1'b1;
              end
            end
            KIND_MRET: begin
              pc_set_o           = 1'b1;
              pc_sel_o           = PC_ERET;
              csr_restore_mret_o = 1'b1;
              redirect_o         = 1'b1;
              nmi_mode_d         = 1'b0;
            end
            default: ;
          endcase
        end
      end
      default: begin
        state_d = RESET;
      end
    endcase
  end

  // trap details straight from the command register
  assign exc_cause_o = cmd.cause;
  assign mtval_o     = cmd.mtval;
  assign epc_o       = cmd.epc;
  assign nmi_mode_o  = nmi_mode_q;
  assign run_o       = (state_q == RUN);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {RESET, BOOT_SET, RUN});

  // no redirect before the boot sequence has started
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_o |-> (state_q != RESET));

endmodule

`default_nettype wire

// File: source/trap_unit.sv
/*
 * trap controller top level
 * capture, select and redirect stages of the trap pipeline
 */
`timescale 1ns/100ps
`default_nettype none
`include "trap_macros.svh"

module trap_unit
  import trap_arch_pkg::*;
  import trap_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // decoded instruction
  input  logic                  instr_valid_i,
  input  logic [`TRAP_XLEN-1:0] instr_i,
  input  logic [`TRAP_XLEN-1:0] pc_i,
  input  priv_lvl_e             priv_i,
  input  logic                  illegal_i,
  input  logic                  ecall_i,
  input  logic                  ebreak_i,
  input  logic                  mret_i,
  input  logic                  fetch_err_i,
  input  logic                  fetch_err_plus2_i,
  output logic                  id_ready_o,
  // interrupts
  input  irqs_t                 irqs_i,
  input  logic                  irq_nm_i,
  input  logic                  mie_i,
  // redirect and CSR side
  output logic                  pc_set_o,
  output pc_sel_e               pc_sel_o,
  output exc_cause_e            exc_cause_o,
  output logic [`TRAP_XLEN-1:0] mtval_o,
  output logic [`TRAP_XLEN-1:0] epc_o,
  output logic                  csr_save_o,
  output logic                  csr_restore_mret_o,
  output logic                  retire_o,
  output logic                  nmi_mode_o
);

  logic redirect;
  logic run;

  trap_req_if req_if ();
  trap_cmd_if cmd_if ();

  trap_capture u_capture (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_i           (instr_i),
    .pc_i              (pc_i),
    .priv_i            (priv_i),
    .illegal_i         (illegal_i),
    .ecall_i           (ecall_i),
    .ebreak_i          (ebreak_i),
    .mret_i            (mret_i),
    .fetch_err_i       (fetch_err_i),
    .fetch_err_plus2_i (fetch_err_plus2_i),
    .irqs_i            (irqs_i),
    .irq_nm_i          (irq_nm_i),
    .mie_i             (mie_i),
    .nmi_mode_i        (nmi_mode_o),
    .redirect_i        (redirect),
    .run_i             (run),
    .id_ready_o        (id_ready_o),
    .req               (req_if)
  );

  trap_select u_select (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req    (req_if),
    .cmd    (cmd_if)
  );

  trap_fsm u_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .cmd                (cmd_if),
    .pc_set_o           (pc_set_o),
    .pc_sel_o           (pc_sel_o),
    .exc_cause_o        (exc_cause_o),
    .mtval_o            (mtval_o),
    .epc_o              (epc_o),
    .csr_save_o         (csr_save_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .retire_o           (retire_o),
    .nmi_mode_o         (nmi_mode_o),
    .redirect_o         (redirect),
    .run_o              (run)
  );

endmodule

`default_nettype wire

// File: test/tb_trap_unit.sv
/*
 * testbench for the trap controller
 * random instructions and interrupts, reference model, checker and watchdog
 */
`timescale 1ns/100ps
`default_nettype none
`include "trap_macros.svh"

module tb_trap_unit
  import trap_arch_pkg::*;
  import trap_ctrl_pkg::*;
();

  localparam int unsigned num_txn      = 400;
  localparam int unsigned reset_cycles = 10;
  localparam int unsigned txn_cycles   = 20;
  localparam int unsigned timeout_ns   = (reset_cycles + 8 + num_txn * txn_cycles) * 20;

  // expected outcome of one accepted instruction
  typedef struct packed {
    trap_kind_e               kind;
    logic [`TRAP_CAUSE_W-1:0] cause;
    logic [`TRAP_XLEN-1:0]    mtval;
    logic [`TRAP_XLEN-1:0]    epc;
    pc_sel_e                  pc_sel;
    logic [31:0]              stamp;
  } expect_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_valid_i;
  logic [`TRAP_XLEN-1:0] instr_i;
  logic [`TRAP_XLEN-1:0] pc_i;
  priv_lvl_e             priv_i;
  logic                  illegal_i;
  logic                  ecall_i;
  logic                  ebreak_i;
  logic                  mret_i;
  logic                  fetch_err_i;
  logic                  fetch_err_plus2_i;
  logic                  id_ready_o;
  irqs_t                 irqs_i;
  logic                  irq_nm_i;
  logic                  mie_i;
  logic                  pc_set_o;
  pc_sel_e               pc_sel_o;
  exc_cause_e            exc_cause_o;
  logic [`TRAP_XLEN-1:0] mtval_o;
  logic [`TRAP_XLEN-1:0] epc_o;
  logic                  csr_save_o;
  logic                  csr_restore_mret_o;
  logic                  retire_o;
  logic                  nmi_mode_o;

  int          seed          = 32'hbd7ac881;
  expect_t     exp_q[$];
  logic [31:0] cyc           = '0;
  logic        boot_done     = 1'b0;
  // handshake seen at the last falling edge
  logic        fire          = 1'b0;
  logic        trap_inflight = 1'b0;
  logic        nmi_model     = 1'b0;
  int unsigned n_accepted    = 0;
  int unsigned n_nmi         = 0;
  int unsigned n_mret        = 0;

  trap_unit dut0 (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic expect_t expect_outcome(
    input logic illegal, input logic ecall, input logic ebreak, input logic mret,
    input logic fetch_err, input logic plus2, input priv_lvl_e priv,
    input logic [`TRAP_XLEN-1:0] pc, input logic [`TRAP_XLEN-1:0] instr,
    input irqs_t irqs, input logic irq_nm, input logic mie, input logic nmi_mode);
    expect_t e;
    logic    take_irq;
    e        = '0;
    e.epc    = pc;
    e.pc_sel = PC_EXC;
    e.kind   = KIND_EXC;
    // NMI bypasses mie and nothing nests inside the NMI handler
    take_irq = !nmi_mode && (irq_nm || (mie && (|irqs)));
    if (take_irq) begin
      e.kind = KIND_IRQ;
      if (irq_nm) begin
        e.cause = IRQ_NM;
      end else if (|irqs.irq_fast) begin
        // search down from the top line
        for (int i = `TRAP_NUM_FAST_IRQ - 1; i >= 0; i--) begin
          if (irqs.irq_fast[i]) begin
            e.cause = `TRAP_CAUSE_W'(32 + `TRAP_FAST_IRQ_BASE + i);
            break;
          end
        end
      end else if (irqs.irq_external) begin
        e.cause = IRQ_EXTERNAL;
      end else if (irqs.irq_software) begin
        e.cause = IRQ_SOFTWARE;
      end else begin
        e.cause = IRQ_TIMER;
      end
    end else if (fetch_err) begin
      e.cause = INSTR_ACCESS_FAULT;
      e.mtval = plus2 ? pc + 32'd2 : pc;
    end else if (illegal || (mret && priv != PRIV_M)) begin
      // mret outside M mode
      e.cause = ILLEGAL_INSN;
      e.mtval = instr;
    end else if (ecall) begin
      e.cause = (priv == PRIV_M) ? ECALL_M : ECALL_U;
    end else if (ebreak) begin
      e.cause = BREAKPOINT;
    end else if (mret) begin
      e.kind   = KIND_MRET;
      e.pc_sel = PC_ERET;
    end else begin
      e.kind = KIND_RETIRE;
    end
    return e;
  endfunction

  task automatic check_outcome(input expect_t e);
    logic is_trap;
    logic is_save;
    is_trap = (e.kind != KIND_RETIRE);
    is_save = (e.kind == KIND_EXC) || (e.kind == KIND_IRQ);
    check_equal("retire", 32'(!is_trap), 32'(retire_o));
    check_equal("pc_set", 32'(is_trap), 32'(pc_set_o));
    check_equal("csr_save", 32'(is_save), 32'(csr_save_o));
    check_equal("csr_restore_mret", 32'(e.kind == KIND_MRET), 32'(csr_restore_mret_o));
    if (is_trap) begin
      check_equal("pc_sel", 32'(e.pc_sel), 32'(pc_sel_o));
      check_equal("epc", e.epc, epc_o);
    end
    if (is_save) begin
      check_equal("cause", 32'(e.cause), 32'(exc_cause_o));
      check_equal("mtval", e.mtval, mtval_o);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] m;
    // sparse lines so that several are sometimes pending at once
    m        = $random(seed) & $random(seed) & $random(seed) & $random(seed) & $random(seed);
    irqs_i   = irqs_t'(m[17:0]);
    r        = $random(seed);
    irq_nm_i = (r[4:0] == 5'd0);
    mie_i    = r[5];
    // fields only change once the last one was taken
    if (!instr_valid_i || fire) begin
      r                 = $random(seed);
      instr_valid_i     = (n_accepted < num_txn) && (r[1:0] != 2'b00);
      priv_i            = r[2] ? PRIV_M : PRIV_U;
      illegal_i         = (r[5:3] == 3'd0);
      ecall_i           = (r[8:6] == 3'd0);
      ebreak_i          = (r[11:9] == 3'd0);
      mret_i            = (r[14:12] == 3'd0);
      fetch_err_i       = (r[17:15] == 3'd0);
      fetch_err_plus2_i = r[18];
      r                 = $random(seed);
      pc_i              = {r[31:1], 1'b0};
      instr_i           = $random(seed);
    end
  endtask

  // monitor and compare on the falling edge where everything is settled
  always @(negedge clk_i) begin
    expect_t e;
    cyc = cyc + 1;
    if (boot_done) begin
      check_equal("nmi_mode", 32'(nmi_model), 32'(nmi_mode_o));
      // handshake stays closed until the redirect
      if (trap_inflight) begin
        check_equal("ready_while_trap_pending", 0, 32'(id_ready_o));
      end
      fire = instr_valid_i && id_ready_o;
      if (fire) begin
        e = expect_outcome(illegal_i, ecall_i, ebreak_i, mret_i, fetch_err_i,
                           fetch_err_plus2_i, priv_i, pc_i, instr_i, irqs_i,
                           irq_nm_i, mie_i, nmi_model);
        e.stamp = cyc;
        exp_q.push_back(e);
        n_accepted++;
        if (e.kind != KIND_RETIRE) begin
          trap_inflight = 1'b1;
        end
      end
      // outcome is due two cycles after acceptance
      if (exp_q.size() != 0 && exp_q[0].stamp + 2 == cyc) begin
        e = exp_q.pop_front();
        check_outcome(e);
        if (e.kind != KIND_RETIRE) begin
          trap_inflight = 1'b0;
        end
        if (e.kind == KIND_IRQ && e.cause == IRQ_NM) begin
          nmi_model = 1'b1;
          n_nmi++;
        end
        if (e.kind == KIND_MRET) begin
          nmi_model = 1'b0;
          n_mret++;
        end
      end else begin
        check_equal("idle_retire", 0, 32'(retire_o));
        check_equal("idle_pc_set", 0, 32'(pc_set_o));
        check_equal("idle_csr_save", 0, 32'(csr_save_o));
        check_equal("idle_csr_restore_mret", 0, 32'(csr_restore_mret_o));
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired before all instructions completed");
    $display("TEST FAIL");
    $fatal(1);
  end

  initial begin
    int unsigned boot_pulses;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_i              = '0;
    priv_i            = PRIV_M;
    illegal_i         = 1'b0;
    ecall_i           = 1'b0;
    ebreak_i          = 1'b0;
    mret_i            = 1'b0;
    fetch_err_i       = 1'b0;
    fetch_err_plus2_i = 1'b0;
    irqs_i            = '0;
    irq_nm_i          = 1'b0;
    mie_i             = 1'b0;
    repeat (reset_cycles) begin
      @(negedge clk_i);
      check_equal("ready_in_reset", 0, 32'(id_ready_o));
      check_equal("pc_set_in_reset", 0, 32'(pc_set_o));
    end
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // one boot redirect with the handshake closed until it has passed
    boot_pulses = 0;
    repeat (4) begin
      @(negedge clk_i);
      if (pc_set_o) begin
        boot_pulses++;
        check_equal("boot_pc_sel", 32'(PC_BOOT), 32'(pc_sel_o));
      end
      if (boot_pulses == 0 || pc_set_o) begin
        check_equal("ready_before_boot", 0, 32'(id_ready_o));
      end
    end
    check_equal("boot_pulses", 1, boot_pulses);
    check_equal("ready_after_boot", 1, 32'(id_ready_o));
    @(posedge clk_i);
    #1;
    boot_done = 1'b1;

    while (n_accepted < num_txn || instr_valid_i || exp_q.size() != 0) begin
      drive_inputs();
      @(posedge clk_i);
      #1;
    end
    repeat (3) @(negedge clk_i);
    // NMI entry and MRET exit both have to show up in the random mix
    check_equal("nmi_exercised", 1, 32'(n_nmi != 0));
    check_equal("mret_exercised", 1, 32'(n_mret != 0));
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/trap_arch_pkg.sv
source/trap_ctrl_pkg.sv
source/trap_if.sv
source/irq_arbiter.sv
source/trap_capture.sv
source/trap_select.sv
source/trap_fsm.sv
source/trap_unit.sv
test/tb_trap_unit.sv

// File: Makefile
# Verilator build and run of the trap unit testbench
TOP := tb_trap_unit

.PHONY: all run lint clean

all: run

# exit status follows the pass message in the simulator output
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

obj_dir/V$(TOP): project.f $(wildcard source/*.sv source/*.svh test/*.sv)
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f

lint:
	verilator --lint-only --timing --top-module trap_unit -f project.f

clean:
	rm -rf obj_dir
